// ==== hdl/exec_pkg.sv ====
// exec_pkg: shared widths, operation encodings and buffer sizing for the execute path
package exec_pkg;

  // datapath and tag widths
  localparam int XLEN  = 32;
  localparam int TAG_W = 6;

  // result buffer sizing
  localparam int RESULT_DEPTH = 4;
  localparam int RESULT_CNT_W = $clog2(RESULT_DEPTH + 1);  // holds 0..RESULT_DEPTH

  typedef logic [XLEN-1:0]  xlen_t;     // data and pc values
  typedef logic [TAG_W-1:0] rob_tag_t;  // reorder-buffer slot

  // alu operation select, riscv funct order where it applies
  typedef enum logic [4:0] {
    ALU_ADD   = 5'd0,
    ALU_SUB   = 5'd1,
    ALU_SLL   = 5'd2,
    ALU_SLT   = 5'd3,
    ALU_SLTU  = 5'd4,
    ALU_XOR   = 5'd5,
    ALU_SRL   = 5'd6,
    ALU_SRA   = 5'd7,
    ALU_OR    = 5'd8,
    ALU_AND   = 5'd9,
    ALU_LUI   = 5'd10,  // immediate passes through
    ALU_AUIPC = 5'd11   // pc + immediate
  } alu_op_e;

  // branch condition select
  typedef enum logic [2:0] {
    BR_BEQ  = 3'd0,
    BR_BNE  = 3'd1,
    BR_BLT  = 3'd2,
    BR_BGE  = 3'd3,
    BR_BLTU = 3'd4,
    BR_BGEU = 3'd5
  } br_op_e;

  // one buffered entry, msb to lsb:
  //   result | rob tag | mispredict | redirect pc
  localparam int wb_entry_w = XLEN + TAG_W + 1 + XLEN;

  // field positions inside an entry
  localparam int ENTRY_NPC_LSB    = 0;
  localparam int ENTRY_MISPRED    = XLEN;
  localparam int ENTRY_TAG_LSB    = XLEN + 1;
  localparam int ENTRY_RESULT_LSB = XLEN + 1 + TAG_W;

endpackage

// ==== hdl/exec_alu.sv ====
// exec_alu: integer alu with branch and jump resolution against the predicted next pc
`timescale 1ns/100ps

module exec_alu import exec_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  // issued micro-op
  input  logic     alu_valid_i,
  input  xlen_t    pc_i,
  input  xlen_t    pred_npc_i,
  input  xlen_t    imm_i,
  input  alu_op_e  alu_op_i,
  input  br_op_e   br_op_i,
  input  logic     is_branch_i,
  input  logic     is_jump_i,
  input  xlen_t    rs1_data_i,
  input  xlen_t    rs2_data_i,
  input  logic     has_rs2_i,
  input  rob_tag_t rob_tag_i,

  // registered result
  output logic     alu_valid_o,
  output rob_tag_t alu_rob_tag_o,
  output xlen_t    alu_result_o,
  output logic     alu_is_mispred_o,
  output xlen_t    alu_redirect_pc_o
);

  xlen_t      op_b;
  logic [4:0] shamt;
  xlen_t      alu_res;
  xlen_t      pc_plus4;
  xlen_t      br_target;
  xlen_t      jalr_target;
  logic       taken;
  xlen_t      actual_npc;
  xlen_t      result_d;
  logic       mispred_d;

  assign op_b     = has_rs2_i ? rs2_data_i : imm_i;
  assign shamt    = op_b[4:0];
  assign pc_plus4 = pc_i + xlen_t'(4);

  // plain alu
  always_comb begin
    case (alu_op_i)
      ALU_ADD:   alu_res = rs1_data_i + op_b;
      ALU_SUB:   alu_res = rs1_data_i - op_b;
      ALU_SLL:   alu_res = rs1_data_i << shamt;
      ALU_SLT:   alu_res = xlen_t'($signed(rs1_data_i) < $signed(op_b));
      ALU_SLTU:  alu_res = xlen_t'(rs1_data_i < op_b);
      ALU_XOR:   alu_res = rs1_data_i ^ op_b;
      ALU_SRL:   alu_res = rs1_data_i >> shamt;
      ALU_SRA:   alu_res = xlen_t'($signed(rs1_data_i) >>> shamt);
      ALU_OR:    alu_res = rs1_data_i | op_b;
      ALU_AND:   alu_res = rs1_data_i & op_b;
      ALU_LUI:   alu_res = imm_i;
      ALU_AUIPC: alu_res = pc_i + imm_i;
      default:   alu_res = '0;
    endcase
  end

  // branch condition always compares the two registers
  always_comb begin
    case (br_op_i)
      BR_BEQ:  taken = (rs1_data_i == rs2_data_i);
      BR_BNE:  taken = (rs1_data_i != rs2_data_i);
      BR_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
      BR_BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      BR_BLTU: taken = (rs1_data_i < rs2_data_i);
      BR_BGEU: taken = (rs1_data_i >= rs2_data_i);
      default: taken = 1'b0;
    endcase
  end

  assign br_target   = pc_i + imm_i;
  assign jalr_target = (rs1_data_i + imm_i) & ~xlen_t'(1);  // lsb dropped per isa

  // actual next pc and writeback value
  always_comb begin
    if (is_jump_i) begin
      actual_npc = has_rs2_i ? jalr_target : br_target;  // has_rs2 marks jalr
      result_d   = pc_plus4;                             // link address
    end else if (is_branch_i) begin
      actual_npc = taken ? br_target : pc_plus4;
      result_d   = '0;
    end else begin
      actual_npc = pc_plus4;
      result_d   = alu_res;
    end
  end

  assign mispred_d = (actual_npc != pred_npc_i);

  // valid strobe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_valid_o <= 1'b0;
    end else begin
      alu_valid_o <= alu_valid_i;
    end
  end

  // payload, only meaningful with alu_valid_o
  always_ff @(posedge clk_i) begin
    if (alu_valid_i) begin
      alu_rob_tag_o     <= rob_tag_i;
      alu_result_o      <= result_d;
      alu_is_mispred_o  <= mispred_d;
      alu_redirect_pc_o <= actual_npc;
    end
  end

endmodule

// ==== hdl/result_fifo.sv ====
// result_fifo: circular buffer of finished results with fall-through head and occupancy count
`timescale 1ns/100ps

module result_fifo import exec_pkg::*; #(
  parameter int DEPTH = 4  // power of two, 2 or more
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  input  logic                         push_i,
  input  logic [wb_entry_w-1:0]        push_data_i,

  input  logic                         pop_i,
  output logic [wb_entry_w-1:0]        head_o,
  output logic                         empty_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [wb_entry_w-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign empty_o = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty_o;

  assign head_o  = mem[rd_ptr];  // first-word fall-through
  assign count_o = count;

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

// ==== hdl/writeback_port.sv ====
// writeback_port: drains the result buffer into reorder-buffer writes and redirect pulses
`timescale 1ns/100ps

module writeback_port import exec_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  logic                  empty_i,
  input  logic [wb_entry_w-1:0] head_i,
  input  logic                  wb_stall_i,  // level from the reorder buffer
  output logic                  pop_o,

  output logic                  wb_valid_o,
  output logic                  redirect_valid_o,
  output rob_tag_t              wb_tag_o,
  output xlen_t                 wb_result_o,
  output xlen_t                 redirect_pc_o
);

  xlen_t    head_result;
  rob_tag_t head_tag;
  logic     head_mispred;
  xlen_t    head_npc;

  // take the head whenever there is one and the rob accepts
  assign pop_o = !empty_i && !wb_stall_i;

  // unpack head fields
  assign head_result  = head_i[ENTRY_RESULT_LSB +: XLEN];
  assign head_tag     = head_i[ENTRY_TAG_LSB +: TAG_W];
  assign head_mispred = head_i[ENTRY_MISPRED];
  assign head_npc     = head_i[ENTRY_NPC_LSB +: XLEN];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o       <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      wb_valid_o       <= pop_o;
      redirect_valid_o <= pop_o && head_mispred;  // aligned with wb_valid_o
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      wb_tag_o      <= head_tag;
      wb_result_o   <= head_result;
      redirect_pc_o <= head_npc;
    end
  end

endmodule

// ==== hdl/exec_top.sv ====
// exec_top: execute path joining the alu, the result buffer and the writeback port
`timescale 1ns/100ps

module exec_top import exec_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  // issue side
  input  logic     alu_valid_i,
  input  xlen_t    pc_i,
  input  xlen_t    pred_npc_i,
  input  xlen_t    imm_i,
  input  alu_op_e  alu_op_i,
  input  br_op_e   br_op_i,
  input  logic     is_branch_i,
  input  logic     is_jump_i,
  input  xlen_t    rs1_data_i,
  input  xlen_t    rs2_data_i,
  input  logic     has_rs2_i,
  input  rob_tag_t rob_tag_i,
  output logic     issue_stall_o,

  // reorder-buffer side
  input  logic     wb_stall_i,
  output logic     wb_valid_o,
  output logic     redirect_valid_o,
  output rob_tag_t wb_tag_o,
  output xlen_t    wb_result_o,
  output xlen_t    redirect_pc_o
);

  logic                    alu_valid;
  rob_tag_t                alu_rob_tag;
  xlen_t                   alu_result;
  logic                    alu_is_mispred;
  xlen_t                   alu_redirect_pc;

  logic [wb_entry_w-1:0]   alu_entry;
  logic [wb_entry_w-1:0]   fifo_head;
  logic                    fifo_empty;
  logic [RESULT_CNT_W-1:0] fifo_count;
  logic                    fifo_pop;
  logic [RESULT_CNT_W:0]   occupancy;  // one spare bit for the sum

  exec_alu i_exec_alu (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .alu_valid_i       (alu_valid_i),
    .pc_i              (pc_i),
    .pred_npc_i        (pred_npc_i),
    .imm_i             (imm_i),
    .alu_op_i          (alu_op_i),
    .br_op_i           (br_op_i),
    .is_branch_i       (is_branch_i),
    .is_jump_i         (is_jump_i),
    .rs1_data_i        (rs1_data_i),
    .rs2_data_i        (rs2_data_i),
    .has_rs2_i         (has_rs2_i),
    .rob_tag_i         (rob_tag_i),
    .alu_valid_o       (alu_valid),
    .alu_rob_tag_o     (alu_rob_tag),
    .alu_result_o      (alu_result),
    .alu_is_mispred_o  (alu_is_mispred),
    .alu_redirect_pc_o (alu_redirect_pc)
  );

  // entry layout matches the field offsets in exec_pkg
  assign alu_entry = {alu_result, alu_rob_tag, alu_is_mispred, alu_redirect_pc};

  result_fifo #(
    .DEPTH (RESULT_DEPTH)
  ) i_result_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (alu_valid),
    .push_data_i (alu_entry),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .empty_o     (fifo_empty),
    .count_o     (fifo_count)
  );

  writeback_port i_writeback_port (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .empty_i          (fifo_empty),
    .head_i           (fifo_head),
    .wb_stall_i       (wb_stall_i),
    .pop_o            (fifo_pop),
    .wb_valid_o       (wb_valid_o),
    .redirect_valid_o (redirect_valid_o),
    .wb_tag_o         (wb_tag_o),
    .wb_result_o      (wb_result_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  // count the op still inside the alu so a new issue always finds a slot
  // pop is ignored here, which is conservative by one cycle at most
  assign occupancy     = fifo_count + alu_valid;
  assign issue_stall_o = (occupancy >= (RESULT_CNT_W + 1)'(RESULT_DEPTH));

endmodule

// ==== bench/tb_clkgen.sv ====
// tb_clkgen: free-running bench clock and power-on reset for the execute path
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 5;   // 10 ns clock
  localparam int RESET_CYCLES = 16;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // release just after an edge
  end

endmodule

// ==== bench/exec_props.sv ====
// exec_props: assertions on buffer room, issue gating and reset state of the execute path
`timescale 1ns/100ps

module exec_props import exec_pkg::*; (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    alu_valid_i,
  input logic                    issue_stall_o,
  input logic                    wb_valid_o,
  input logic                    fifo_push,
  input logic [RESULT_CNT_W-1:0] fifo_count
);

  int assert_fails = 0;  // read by the testbench at the end

  // a finished result always finds a free slot
  push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo_push |-> (fifo_count != RESULT_CNT_W'(RESULT_DEPTH)))
    else begin
      $error("result pushed into a full buffer");
      assert_fails++;
    end

  issue_not_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alu_valid_i |-> !issue_stall_o)
    else begin
      $error("issue strobe while issue_stall_o is high");
      assert_fails++;
    end

  wb_quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_valid_o)
    else begin
      $error("wb_valid_o high during reset");
      assert_fails++;
    end

endmodule

bind exec_top exec_props i_exec_props (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .alu_valid_i   (alu_valid_i),
  .issue_stall_o (issue_stall_o),
  .wb_valid_o    (wb_valid_o),
  .fifo_push     (alu_valid),
  .fifo_count    (fifo_count)
);

// ==== bench/tb_exec_top.sv ====
// tb_exec_top: testbench for the execute path with reference model, in-order checker and watchdog
`timescale 1ns/100ps

module tb_exec_top import exec_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DLY    = 1;  // ns after the rising edge
  localparam int N_ALU        = 12 * 2 * 3;
  localparam int N_BRANCH     = 6 * 4 * 2;
  localparam int N_JUMP       = 16;
  localparam int N_STRESS     = 200;
  localparam int TOTAL_OPS    = N_ALU + N_BRANCH + N_JUMP + 1 + N_STRESS;
  localparam int WB_LATENCY   = 2;  // edges from the one that samples the strobe

  logic     clk_i;
  logic     rst_n_i;
  logic     alu_valid_i = 1'b0;
  xlen_t    pc_i        = '0;
  xlen_t    pred_npc_i  = '0;
  xlen_t    imm_i       = '0;
  alu_op_e  alu_op_i    = ALU_ADD;
  br_op_e   br_op_i     = BR_BEQ;
  logic     is_branch_i = 1'b0;
  logic     is_jump_i   = 1'b0;
  xlen_t    rs1_data_i  = '0;
  xlen_t    rs2_data_i  = '0;
  logic     has_rs2_i   = 1'b0;
  rob_tag_t rob_tag_i   = '0;
  logic     wb_stall_i  = 1'b0;
  logic     issue_stall_o;
  logic     wb_valid_o;
  logic     redirect_valid_o;
  rob_tag_t wb_tag_o;
  xlen_t    wb_result_o;
  xlen_t    redirect_pc_o;

  integer   seed         = 32'h73f8_a751;
  int       value_errors = 0;
  int       other_errors = 0;
  int       issue_count  = 0;
  int       wb_count     = 0;
  int       cycle_cnt    = 0;
  int       issue_cycle  = 0;
  int       wb_cycle     = 0;
  logic     stall_rand   = 1'b0;  // wb_stall_i random when set
  rob_tag_t next_tag     = '0;

  // expected writebacks, oldest first
  rob_tag_t exp_tag_q[$];
  xlen_t    exp_result_q[$];
  logic     exp_mispred_q[$];
  xlen_t    exp_npc_q[$];

  // equal, less, greater, and signed vs unsigned disagreement
  xlen_t br_rs1 [4] = '{32'h1234_5678, 32'd5, 32'd9, 32'hffff_fff0};
  xlen_t br_rs2 [4] = '{32'h1234_5678, 32'd9, 32'd5, 32'h0000_0010};

  tb_clkgen i_tb_clkgen (.clk_o(clk_i), .rst_n_o(rst_n_i));

  exec_top i_exec_top (.*);

  // expected result and next pc of the op on the issue ports
  function automatic void model_op(output xlen_t res, output xlen_t npc);
    xlen_t b;
    logic  taken;
    b     = has_rs2_i ? rs2_data_i : imm_i;
    res   = '0;
    npc   = pc_i + 32'd4;
    taken = 1'b0;
    if (is_jump_i) begin
      res = pc_i + 32'd4;  // link
      npc = has_rs2_i ? ((rs1_data_i + imm_i) & 32'hffff_fffe) : (pc_i + imm_i);
    end else if (is_branch_i) begin
      case (br_op_i)
        BR_BEQ:  taken = (rs1_data_i == rs2_data_i);
        BR_BNE:  taken = (rs1_data_i != rs2_data_i);
        BR_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
        BR_BGE:  taken = !($signed(rs1_data_i) < $signed(rs2_data_i));
        BR_BLTU: taken = (rs1_data_i < rs2_data_i);
        BR_BGEU: taken = !(rs1_data_i < rs2_data_i);
        default: taken = 1'b0;
      endcase
      if (taken) begin
        npc = pc_i + imm_i;
      end
    end else begin
      case (alu_op_i)
        ALU_ADD:   res = rs1_data_i + b;
        ALU_SUB:   res = rs1_data_i + ~b + 32'd1;
        ALU_SLL:   res = rs1_data_i << b[4:0];
        ALU_SLT:   res = ($signed(rs1_data_i) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU:  res = (rs1_data_i < b) ? 32'd1 : 32'd0;
        ALU_XOR:   res = rs1_data_i ^ b;
        ALU_SRL:   res = rs1_data_i >> b[4:0];
        ALU_SRA:   res = $signed(rs1_data_i) >>> b[4:0];
        ALU_OR:    res = rs1_data_i | b;
        ALU_AND:   res = rs1_data_i & b;
        ALU_LUI:   res = imm_i;
        ALU_AUIPC: res = pc_i + imm_i;
        default:   res = '0;
      endcase
    end
  endfunction

  function automatic xlen_t rand_pc();
    return xlen_t'($random(seed)) & 32'hffff_fffc;
  endfunction

  // 12-bit signed, even offset
  function automatic xlen_t rand_imm();
    xlen_t r;
    r = $random(seed);
    return {{20{r[11]}}, r[11:1], 1'b0};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic step_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
    alu_valid_i = 1'b0;
    if (stall_rand) begin
      wb_stall_i = 1'($random(seed));
    end
  endtask

  task automatic issue_op(
    input alu_op_e op,
    input br_op_e  bop,
    input logic    is_br,
    input logic    is_jmp,
    input logic    use_rs2,
    input xlen_t   pc,
    input xlen_t   imm,
    input xlen_t   rs1,
    input xlen_t   rs2,
    input logic    pred_ok
  );
    xlen_t res;
    xlen_t npc;
    step_cycle();
    while (issue_stall_o) begin
      step_cycle();
    end
    alu_op_i    = op;
    br_op_i     = bop;
    is_branch_i = is_br;
    is_jump_i   = is_jmp;
    has_rs2_i   = use_rs2;
    pc_i        = pc;
    imm_i       = imm;
    rs1_data_i  = rs1;
    rs2_data_i  = rs2;
    model_op(res, npc);
    pred_npc_i  = pred_ok ? npc : npc + 32'd8;  // wrong guess lands elsewhere
    rob_tag_i   = next_tag;
    alu_valid_i = 1'b1;
    exp_tag_q.push_back(next_tag);
    exp_result_q.push_back(res);
    exp_mispred_q.push_back(npc != pred_npc_i);
    exp_npc_q.push_back(npc);
    next_tag    = next_tag + 1'b1;
    issue_cycle = cycle_cnt + 1;  // edge that samples the strobe
    issue_count++;
  endtask

  task automatic drain();
    while (exp_tag_q.size() != 0) begin
      step_cycle();
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // in-order compare, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i && wb_valid_o) begin
      wb_count++;
      wb_cycle = cycle_cnt;
      if (exp_tag_q.size() == 0) begin
        $display("writeback of tag 0x%0h arrived with no op outstanding", wb_tag_o);
        other_errors++;
      end else begin
        check_value("wb_tag_o", wb_tag_o, exp_tag_q.pop_front());
        check_value("wb_result_o", wb_result_o, exp_result_q.pop_front());
        check_value("redirect_valid_o", redirect_valid_o, exp_mispred_q.pop_front());
        check_value("redirect_pc_o", redirect_pc_o, exp_npc_q.pop_front());
      end
    end else if (rst_n_i) begin
      check_value("redirect_valid_o", redirect_valid_o, 32'd0);  // no pulse alone
    end
  end

  initial begin
    repeat (RESET_CYCLES + TOTAL_OPS * 20) @(posedge clk_i);
    $display("timeout: writebacks did not complete within %0d cycles",
             RESET_CYCLES + TOTAL_OPS * 20);
    $display("Regression failed");
    $finish;
  end

  initial begin
    xlen_t a;
    xlen_t b;
    int    kind;
    int    op_sel;
    int    br_sel;
    wait (rst_n_i === 1'b1);

    // quiet outputs before the first issue
    repeat (4) begin
      @(negedge clk_i);
      check_value("wb_valid_o", wb_valid_o, 32'd0);
      check_value("redirect_valid_o", redirect_valid_o, 32'd0);
      check_value("issue_stall_o", issue_stall_o, 32'd0);
    end

    for (int op = 0; op < 12; op++) begin
      for (int form = 0; form < 2; form++) begin
        repeat (3) begin
          a = $random(seed);
          b = $random(seed);
          issue_op(alu_op_e'(op), BR_BEQ, 1'b0, 1'b0, form[0], rand_pc(), b, a,
                   b ^ 32'h5a5a_0f0f, 1'b1);
        end
      end
    end

    // every branch with each operand pair, right and wrong guess
    for (int bop = 0; bop < 6; bop++) begin
      for (int pair = 0; pair < 4; pair++) begin
        for (int ok = 0; ok < 2; ok++) begin
          b = rand_imm();
          issue_op(ALU_ADD, br_op_e'(bop), 1'b1, 1'b0, 1'b1, rand_pc(), b,
                   br_rs1[pair], br_rs2[pair], ok[0]);
        end
      end
    end

    // jal when j[1] clear, jalr otherwise; j[2] makes the jalr sum odd
    for (int j = 0; j < N_JUMP; j++) begin
      a = (xlen_t'($random(seed)) & 32'hffff_fffe) | xlen_t'(j[2]);
      b = rand_imm();
      issue_op(ALU_ADD, BR_BEQ, 1'b0, 1'b1, j[1], rand_pc(), b, a, 32'd0, j[0]);
    end

    // isolated op into an empty buffer
    drain();
    issue_op(ALU_ADD, BR_BEQ, 1'b0, 1'b0, 1'b0, rand_pc(), 32'd1, 32'd2, 32'd0, 1'b1);
    drain();
    check_value("wb latency", wb_cycle - issue_cycle, WB_LATENCY);

    // mixed traffic against random writeback stalls
    stall_rand = 1'b1;
    repeat (N_STRESS) begin
      kind   = {$random(seed)} % 4;  // 0,1 alu 2 branch 3 jump
      op_sel = {$random(seed)} % 12;
      br_sel = {$random(seed)} % 6;
      a      = $random(seed);
      b      = a[1] ? a : xlen_t'($random(seed));
      issue_op(alu_op_e'(op_sel), br_op_e'(br_sel), kind == 2, kind == 3,
               a[2] || (kind == 2), rand_pc(), rand_imm(), a, b, b[3]);
    end
    drain();
    stall_rand = 1'b0;
    wb_stall_i = 1'b0;

    check_value("writeback count", wb_count, issue_count);
    other_errors += i_exec_top.i_exec_props.assert_fails;
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/result_fifo.sv
hdl/writeback_port.sv
hdl/exec_top.sv
bench/tb_clkgen.sv
bench/exec_props.sv
bench/tb_exec_top.sv
